//--- Bender.yml
package:
  name: fetch_stage

sources:
  - logic/fetch_pkg.sv
  - logic/pc.sv
  - logic/next_pc_select.sv
  - logic/instr_mem.sv
  - logic/if_id_reg.sv
  - logic/fetch_stage.sv
  - target: test
    files:
      - tests/tb_fetch_stage.sv

//--- compile.f
logic/fetch_pkg.sv
logic/pc.sv
logic/next_pc_select.sv
logic/instr_mem.sv
logic/if_id_reg.sv
logic/fetch_stage.sv
tests/tb_fetch_stage.sv

//--- logic/fetch_pkg.sv
`default_nettype none

// Widths, vector types and encodings shared by the fetch stage blocks
package fetch_pkg;

    // Datapath widths
    localparam int unsigned PC_WIDTH    = 32;  // Byte address width
    localparam int unsigned INSTR_WIDTH = 32;  // One instruction word

    // Distance in bytes between two consecutive instructions
    localparam int unsigned PC_STEP = 4;

    // Byte address or program counter value
    typedef logic [PC_WIDTH-1:0] pc_t;

    // Raw instruction word as stored in memory
    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // All-zero word used as the bubble in IF/ID
    localparam instr_t NOP_INSTR = '0;

    // Program counter FSM
    // The encoding 2'b11 is never entered
    typedef enum logic [1:0]
    {
        PC_IDLE = 2'b00,  // Waiting one cycle with PC at zero
        PC_NEXT = 2'b01,  // Fetching and advancing
        PC_END  = 2'b10   // Halted until i_halt drops
    } pc_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction fetch stage
// PC, next address logic, instruction memory and the IF/ID register
module fetch_stage
    import fetch_pkg::*;
    #(
        parameter int unsigned MEM_DEPTH = 64  // Instruction memory depth in words
    )
    (
        input  wire    i_clk,            // System clock
        input  wire    i_rst_n,          // Asynchronous reset, active low
        input  wire    i_enable,         // Run level
        input  wire    i_halt,           // Halt instruction reached
        input  wire    i_stall,          // Hazard stall
        input  wire    i_flush,          // Empty IF/ID
        input  wire    i_clear,          // Program reload
        input  wire    i_branch_taken,   // Branch taken from execute
        input  pc_t    i_branch_target,  // Branch destination
        input  wire    i_jump,           // Jump from decode
        input  pc_t    i_jump_target,    // Jump destination
        input  wire    i_load_we,        // Loader write strobe
        input  pc_t    i_load_addr,      // Loader byte address
        input  instr_t i_load_data,      // Loader word
        output pc_t    o_pc,             // IF/ID address
        output pc_t    o_pc_plus4,       // IF/ID successor address
        output instr_t o_instr,          // IF/ID instruction
        output logic   o_valid,          // IF/ID holds a real instruction
        output logic   o_halted          // PC FSM in END
    );

    pc_t    pc_cur;       // Current fetch address
    pc_t    next_pc;      // Selected next address
    pc_t    pc_plus4;     // Sequential successor
    instr_t instr;        // Word at pc_cur
    logic   fetch_valid;  // Fetch this cycle is real

    pc u_pc (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_halt        (i_halt),
        .i_not_load    (i_stall),  // Stall holds the PC
        .i_clear       (i_clear),
        .i_next_pc     (next_pc),
        .o_pc          (pc_cur),
        .o_fetch_valid (fetch_valid),
        .o_halted      (o_halted)
    );

    next_pc_select u_next_pc_select (
        .i_pc            (pc_cur),
        .i_branch_taken  (i_branch_taken),
        .i_branch_target (i_branch_target),
        .i_jump          (i_jump),
        .i_jump_target   (i_jump_target),
        .o_next_pc       (next_pc),
        .o_pc_plus4      (pc_plus4)
    );

    instr_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_instr_mem (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_pc        (pc_cur),
        .o_instr     (instr)
    );

    if_id_reg u_if_id_reg (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_enable      (i_enable),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_clear       (i_clear),
        .i_fetch_valid (fetch_valid),
        .i_pc          (pc_cur),
        .i_pc_plus4    (pc_plus4),
        .i_instr       (instr),
        .o_pc          (o_pc),
        .o_pc_plus4    (o_pc_plus4),
        .o_instr       (o_instr),
        .o_valid       (o_valid)
    );

endmodule

`default_nettype wire

//--- logic/if_id_reg.sv
`timescale 1ns/1ps
`default_nettype none

// IF/ID pipeline register between fetch and decode
module if_id_reg
    import fetch_pkg::*;
    (
        input  wire    i_clk,          // System clock
        input  wire    i_rst_n,        // Asynchronous reset, active low
        input  wire    i_enable,       // Run level
        input  wire    i_stall,        // Hazard hold
        input  wire    i_flush,        // Branch resolved and wrong path is dropped
        input  wire    i_clear,        // Program reload
        input  wire    i_fetch_valid,  // Fetch stage has a real instruction
        input  pc_t    i_pc,           // Address of the fetched word
        input  pc_t    i_pc_plus4,     // Its sequential successor
        input  instr_t i_instr,        // Fetched word
        output pc_t    o_pc,           // Registered address
        output pc_t    o_pc_plus4,     // Registered successor
        output instr_t o_instr,        // Registered instruction
        output logic   o_valid         // Registered instruction is real
    );

    logic capture;  // Register takes new fetch data

    // Same condition that lets the PC move
    assign capture = i_enable && !i_stall;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_pc       <= '0;
            o_pc_plus4 <= '0;
            o_instr    <= NOP_INSTR;
            o_valid    <= 1'b0;
        end
        else if (i_flush || i_clear)
        begin
            // Bubble wins over stall
            o_instr <= NOP_INSTR;
            o_valid <= 1'b0;
        end
        else if (capture)
        begin
            o_pc       <= i_pc;
            o_pc_plus4 <= i_pc_plus4;
            o_instr    <= i_instr;
            o_valid    <= i_fetch_valid;  // Low while the PC is idle or halted
        end
        // Otherwise hold everything
    end

    // A flush always leaves a bubble for decode on the next cycle
    a_flush_bubble : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !o_valid
    );

endmodule

`default_nettype wire

//--- logic/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

// Word-addressed instruction memory
// Filled by an external loader and read combinationally at the PC
module instr_mem
    import fetch_pkg::*;
    #(
        parameter int unsigned MEM_DEPTH = 64  // Number of instruction words
    )
    (
        input  wire    i_clk,        // System clock
        input  wire    i_rst_n,      // Asynchronous reset, active low
        input  wire    i_load_we,    // Loader write strobe
        input  pc_t    i_load_addr,  // Loader byte address
        input  instr_t i_load_data,  // Word to store
        input  pc_t    i_pc,         // Fetch address
        output instr_t o_instr       // Word at the fetch address
    );

    // Byte offset bits dropped to form a word index
    localparam int unsigned ADDR_LSB  = $clog2(PC_STEP);
    localparam int unsigned IDX_WIDTH = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    instr_t mem [MEM_DEPTH];  // Storage array

    pc_t  load_word;       // Loader word index
    pc_t  fetch_word;      // Fetch word index
    logic load_in_range;   // Loader address inside the array
    logic fetch_in_range;  // Fetch address inside the array

    // Byte address to word index
    assign load_word  = i_load_addr >> ADDR_LSB;
    assign fetch_word = i_pc >> ADDR_LSB;

    assign load_in_range  = load_word < pc_t'(MEM_DEPTH);
    assign fetch_in_range = fetch_word < pc_t'(MEM_DEPTH);

    // Loader write port
    // Reset clears the whole program
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
            begin
                mem[i] <= NOP_INSTR;
            end
        end
        else if (i_load_we && load_in_range)
        begin
            mem[load_word[IDX_WIDTH-1:0]] <= i_load_data;  // Out of range writes are dropped
        end
    end

    // Read port with no latency
    always_comb
    begin
        if (fetch_in_range)
        begin
            o_instr = mem[fetch_word[IDX_WIDTH-1:0]];
        end
        else
        begin
            o_instr = NOP_INSTR;  // Beyond the end reads as a bubble
        end
    end

    // Loader only writes whole words
    a_load_aligned : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_load_we |-> (i_load_addr[ADDR_LSB-1:0] == '0)
    );

endmodule

`default_nettype wire

//--- logic/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

// Next fetch address selection
// Priority is jump first, then taken branch, then sequential PC+4
module next_pc_select
    import fetch_pkg::*;
    (
        input  pc_t i_pc,             // Current program counter
        input  wire i_branch_taken,   // Branch resolved as taken
        input  pc_t i_branch_target,  // Branch destination
        input  wire i_jump,           // Unconditional jump
        input  pc_t i_jump_target,    // Jump destination
        output pc_t o_next_pc,        // Address to load at the next advance
        output pc_t o_pc_plus4        // Sequential successor
    );

    pc_t seq_pc;  // Current PC plus one instruction

    // Sequential address
    assign seq_pc = i_pc + pc_t'(PC_STEP);

    // Target priority
    always_comb
    begin
        if (i_jump)
        begin
            o_next_pc = i_jump_target;    // Jump overrides everything
        end
        else if (i_branch_taken)
        begin
            o_next_pc = i_branch_target;  // Taken branch
        end
        else
        begin
            o_next_pc = seq_pc;           // Fall through
        end
    end

    assign o_pc_plus4 = seq_pc;  // Return address for the decode stage

    // A redirect from decode or execute must land on a word boundary
    a_target_aligned : assert final (
        !(i_jump || i_branch_taken) || (o_next_pc[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

//--- logic/pc.sv
`timescale 1ns/1ps
`default_nettype none

// Program counter register with its IDLE / NEXT / END state machine
module pc
    import fetch_pkg::*;
    (
        input  wire  i_clk,          // System clock
        input  wire  i_rst_n,        // Asynchronous reset, active low
        input  wire  i_enable,       // Run level from the debug unit
        input  wire  i_halt,         // Halt instruction reached
        input  wire  i_not_load,     // Hold the PC (hazard stall)
        input  wire  i_clear,        // Synchronous return to address zero
        input  pc_t  i_next_pc,      // Address chosen by next_pc_select
        output pc_t  o_pc,           // Current fetch address
        output logic o_fetch_valid,  // An instruction is fetched this cycle
        output logic o_halted        // Sitting in PC_END
    );

    pc_state_e state;       // Current FSM state
    pc_state_e state_next;  // FSM state for the next edge
    pc_t       pc_q;        // Program counter register
    pc_t       pc_next;     // Program counter for the next edge

    // State and PC update
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state <= PC_IDLE;
            pc_q  <= '0;
        end
        else if (i_clear)
        begin
            // Program reload starts over from address zero
            state <= PC_IDLE;
            pc_q  <= '0;
        end
        else
        begin
            state <= state_next;
            pc_q  <= pc_next;
        end
    end

    // Next state and next PC
    always_comb
    begin
        state_next = state;  // Default is to hold
        pc_next    = pc_q;

        case (state)
            PC_IDLE:
            begin
                pc_next    = '0;       // Execution always begins at zero
                state_next = PC_NEXT;
            end

            PC_NEXT:
            begin
                if (i_enable)
                begin
                    if (i_halt)
                        state_next = PC_END;  // PC keeps the halt address
                    else if (!i_not_load)
                        pc_next = i_next_pc;  // Normal advance
                end
            end

            PC_END:
            begin
                // Leave once the halt request is gone
                if (!i_halt)
                    state_next = PC_IDLE;
            end

            default:
            begin
                state_next = PC_IDLE;  // Recover from the unused encoding
            end
        endcase
    end

    assign o_pc          = pc_q;
    assign o_fetch_valid = (state == PC_NEXT) && i_enable && !i_halt;
    assign o_halted      = (state == PC_END);

    // FSM never sits in the unused encoding
    a_state_legal : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        state inside {PC_IDLE, PC_NEXT, PC_END}
    );

    // Every fetch address is on a word boundary
    a_pc_aligned : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        pc_q[1:0] == 2'b00
    );

endmodule

`default_nettype wire

//--- tests/fetch_stimulus.txt
# L addr data | C en halt stall flush clear br br_tgt jmp jmp_tgt pc instr valid halted
# C outputs are sampled before the edge that takes the line's inputs, V and H wait for valid/halt
L 00 a0000000
L 04 a0000004
L 08 a0000008
L 0c a000000c
L 10 a0000010
L 14 a0000014
L 30 a0000030
L 38 a0000038
L 40 a0000040
C 1 0 0 0 0 0 00 0 00 00 00000000 0 0
V
C 1 0 1 0 0 0 00 0 00 04 a0000004 1 0
C 1 0 1 0 0 0 00 0 00 04 a0000004 1 0
C 1 0 0 0 0 0 00 0 00 04 a0000004 1 0
C 1 0 0 1 0 1 30 0 00 08 a0000008 1 0
C 1 0 0 0 0 0 00 0 00 08 00000000 0 0
C 1 0 0 1 0 1 10 1 38 30 a0000030 1 0
C 1 0 0 0 0 0 00 0 00 30 00000000 0 0
C 1 0 0 0 0 0 00 0 00 38 a0000038 1 0
C 1 0 0 0 0 0 00 0 00 3c 00000000 1 0
C 1 1 0 0 0 0 00 0 00 40 00000000 1 0
H
C 1 1 0 0 0 0 00 0 00 44 00000000 0 1
C 1 0 0 0 0 0 00 0 00 44 00000000 0 1
C 1 0 0 0 0 0 00 0 00 44 00000000 0 0
C 1 0 0 0 0 0 00 0 00 44 00000000 0 0
C 1 0 0 0 0 0 00 0 00 00 a0000000 1 0
C 0 0 0 0 0 0 00 0 00 04 a0000004 1 0
C 0 0 0 0 0 0 00 0 00 04 a0000004 1 0
C 1 0 0 0 1 0 00 0 00 04 a0000004 1 0
C 1 0 0 0 0 0 00 0 00 04 00000000 0 0
C 1 0 0 0 0 0 00 0 00 00 a0000000 0 0
C 0 0 0 0 0 0 00 0 00 00 a0000000 1 0

//--- tests/tb_fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch stage testbench
// Loads a program and replays per-cycle control vectors from a stimulus file
module tb_fetch_stage
    import fetch_pkg::*;
    ();

    localparam int unsigned MEM_DEPTH  = 16;  // Small memory so 0x40 is already out of range
    localparam int unsigned WAIT_LIMIT = 50;  // Cycles allowed for any event wait

    logic   i_clk;
    logic   i_rst_n;
    logic   i_enable, i_halt, i_stall, i_flush, i_clear;  // Later stage levels
    logic   i_branch_taken, i_jump;
    pc_t    i_branch_target, i_jump_target;
    logic   i_load_we;                                    // Loader port
    pc_t    i_load_addr;
    instr_t i_load_data;
    pc_t    o_pc, o_pc_plus4;                             // IF/ID outputs
    instr_t o_instr;
    logic   o_valid, o_halted;

    fetch_stage #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_fetch_stage (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_enable        (i_enable),
        .i_halt          (i_halt),
        .i_stall         (i_stall),
        .i_flush         (i_flush),
        .i_clear         (i_clear),
        .i_branch_taken  (i_branch_taken),
        .i_branch_target (i_branch_target),
        .i_jump          (i_jump),
        .i_jump_target   (i_jump_target),
        .i_load_we       (i_load_we),
        .i_load_addr     (i_load_addr),
        .i_load_data     (i_load_data),
        .o_pc            (o_pc),
        .o_pc_plus4      (o_pc_plus4),
        .o_instr         (o_instr),
        .o_valid         (o_valid),
        .o_halted        (o_halted)
    );

    always #4 i_clk = ~i_clk;  // 8 ns period

    // Print the reason, then stop the run
    task automatic report_failure(input string msg);
        begin
            $display("%s", msg);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_pc(input string what, input pc_t got, input pc_t exp);
        begin
            if (got !== exp)
                report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                         $time, what, got, exp));
        end
    endtask

    task automatic check_instr(input string what, input instr_t got, input instr_t exp);
        begin
            if (got !== exp)
                report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                         $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        begin
            if (got !== exp)
                report_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                         $time, what, got, exp));
        end
    endtask

    // Step cycles with the inputs held until o_valid or o_halted is seen
    task automatic wait_for_event(input logic for_halt);
        int unsigned cycles;
        logic        seen;
        begin
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < WAIT_LIMIT)
            begin
                @(posedge i_clk);
                #1;
                i_load_we = 1'b0;
                #6;                                   // Sample just before the next edge
                seen = for_halt ? o_halted : o_valid;
                cycles++;
            end
            if (!seen && for_halt)
                report_failure("Timeout: o_halted never rose after the halt request");
            else if (!seen)
                report_failure("Timeout: o_valid never rose, no instruction was fetched");
        end
    endtask

    initial
    begin : run
        int          fd;
        int          code;
        int          ch;
        int          checks;
        logic [63:0] tag;                            // First word of a stimulus line
        logic        en, halt, stall, flush, clear, br, jmp;
        logic        exp_valid, exp_halted;
        pc_t         br_tgt, jmp_tgt, exp_pc, addr;
        instr_t      data, exp_instr;

        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_enable        = 1'b0;  // Stage stays frozen while the program loads
        i_halt          = 1'b0;
        i_stall         = 1'b0;
        i_flush         = 1'b0;
        i_clear         = 1'b0;
        i_branch_taken  = 1'b0;
        i_branch_target = '0;
        i_jump          = 1'b0;
        i_jump_target   = '0;
        i_load_we       = 1'b0;
        i_load_addr     = '0;
        i_load_data     = '0;
        checks          = 0;

        fd = $fopen("tests/fetch_stimulus.txt", "r");
        if (fd == 0)
            report_failure("Could not open tests/fetch_stimulus.txt");

        repeat (2) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        code = $fscanf(fd, "%s", tag);
        while (code == 1)
        begin
            if (tag == "#")
            begin
                ch = $fgetc(fd);                     // Drop the rest of a comment line
                while (ch != "\n" && ch != -1)
                    ch = $fgetc(fd);
            end
            else if (tag == "L")
            begin
                code = $fscanf(fd, "%h %h", addr, data);
                if (code != 2)
                    report_failure("Malformed load line in the stimulus file");
                @(posedge i_clk);
                #1;
                i_load_we   = 1'b1;                  // One word per cycle
                i_load_addr = addr;
                i_load_data = data;
            end
            else if (tag == "C")
            begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                               en, halt, stall, flush, clear, br, br_tgt, jmp, jmp_tgt,
                               exp_pc, exp_instr, exp_valid, exp_halted);
                if (code != 13)
                    report_failure("Malformed cycle line in the stimulus file");
                @(posedge i_clk);
                #1;
                i_load_we       = 1'b0;
                i_enable        = en;
                i_halt          = halt;
                i_stall         = stall;
                i_flush         = flush;
                i_clear         = clear;
                i_branch_taken  = br;
                i_branch_target = br_tgt;
                i_jump          = jmp;
                i_jump_target   = jmp_tgt;
                #6;                                  // Registered outputs are settled here
                check_pc("o_pc", o_pc, exp_pc);
                check_instr("o_instr", o_instr, exp_instr);
                check_flag("o_valid", o_valid, exp_valid);
                check_flag("o_halted", o_halted, exp_halted);
                if (exp_valid)
                    check_pc("o_pc_plus4", o_pc_plus4, exp_pc + pc_t'(PC_STEP));
                checks++;
            end
            else if (tag == "V")
                wait_for_event(1'b0);
            else if (tag == "H")
                wait_for_event(1'b1);
            else
                report_failure("Unknown line type in the stimulus file");
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);

        if (checks == 0)
            report_failure("The stimulus file held no cycle lines");
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
